// ==== include/ieu_settings.svh ====
// Execute stage width settings
`ifndef IEU_SETTINGS_SVH
`define IEU_SETTINGS_SVH

// Data word width
`define IEU_DW 32

// Byte address width
`define IEU_AW 32

// Register index width
`define IEU_REG_AW 5

`endif

// ==== verilog/ieu_flow_pkg.sv ====
// Execute stage control-flow types
`default_nettype none

`include "ieu_settings.svh"

package ieu_flow_pkg;

   // Kind of speculated control transfer
   typedef enum logic [1:0] {
      br_none   = 2'd0,
      br_jmprel = 2'd1, // Conditional, PC relative
      br_jmpfar = 2'd2  // Register indirect
   } branch_e;

   // Fetch redirect, target is a word address
   typedef struct packed {
      logic                flush;
      logic [`IEU_AW-3:0]  target;
   } redirect_t;

   // Branch predictor update
   typedef struct packed {
      logic                valid;
      logic                jmprel; // Clear for far jumps
      logic                hit;
      logic [`IEU_AW-3:0]  insn_pc;
   } bpu_report_t;

   typedef enum logic {
      fl_idle = 1'b0,
      fl_hold = 1'b1  // Waiting for fetch to ack
   } flush_state_e;

endpackage

`default_nettype wire

// ==== verilog/ieu_isa_pkg.sv ====
// Execute stage datapath types
`default_nettype none

`include "ieu_settings.svh"

package ieu_isa_pkg;

   import ieu_flow_pkg::*;

   typedef logic [`IEU_DW-1:0]     word_t;
   typedef logic [`IEU_REG_AW-1:0] reg_addr_t;
   typedef logic [`IEU_AW-3:0]     pc_t;   // Byte address without bits 1:0

   typedef enum logic [3:0] {
      alu_none    = 4'd0,
      alu_add     = 4'd1,
      alu_sub     = 4'd2,
      alu_cmp_eq  = 4'd3,
      alu_cmp_lt  = 4'd4,  // Signed
      alu_cmp_ltu = 4'd5,
      alu_and     = 4'd6,
      alu_or      = 4'd7,
      alu_xor     = 4'd8,
      alu_sll     = 4'd9,
      alu_srl     = 4'd10,
      alu_sra     = 4'd11,
      alu_link    = 4'd12  // Write return address
   } alu_op_e;

   // One decoded instruction as presented by issue
   typedef struct packed {
      word_t      operand_1;
      word_t      operand_2;
      alu_op_e    op;
      logic       wb_en;
      reg_addr_t  wb_addr;
      pc_t        insn_pc;
      branch_e    branch;
      logic       specul_bcc;  // Predicted condition for jmprel
      pc_t        specul_tgt;  // Predicted target
   } issue_t;

endpackage

`default_nettype wire

// ==== verilog/ieu_arith_unit.sv ====
// Adder and compare unit
`timescale 1ns/1ps
`default_nettype none

module ieu_arith_unit (
   input  ieu_isa_pkg::issue_t issue,
   output ieu_isa_pkg::word_t  arith_result,
   input  logic                accept,
   output logic                cc_we,
   output logic                cc_nxt
);

   import ieu_isa_pkg::*;

   logic is_cmp;

   always_comb begin
      arith_result = '0;
      cc_nxt       = 1'b0;
      is_cmp       = 1'b0;
      case (issue.op)
         alu_add: arith_result = issue.operand_1 + issue.operand_2;
         alu_sub: arith_result = issue.operand_1 - issue.operand_2;
         alu_cmp_eq: begin
            is_cmp = 1'b1;
            cc_nxt = (issue.operand_1 == issue.operand_2);
         end
         alu_cmp_lt: begin
            is_cmp = 1'b1;
            cc_nxt = ($signed(issue.operand_1) < $signed(issue.operand_2));
         end
         alu_cmp_ltu: begin
            is_cmp = 1'b1;
            cc_nxt = (issue.operand_1 < issue.operand_2);
         end
         default: ;  // Not an adder op
      endcase
   end

   // Flag only changes on a committed compare
   assign cc_we = accept & is_cmp;

endmodule

`default_nettype wire

// ==== verilog/ieu_logic_unit.sv ====
// Bitwise and shift unit
`timescale 1ns/1ps
`default_nettype none

`include "ieu_settings.svh"

module ieu_logic_unit (
   input  ieu_isa_pkg::issue_t issue,
   output ieu_isa_pkg::word_t  logic_result
);

   import ieu_isa_pkg::*;

   localparam int shamt_w = $clog2(`IEU_DW);

   logic [shamt_w-1:0] shamt;

   assign shamt = issue.operand_2[shamt_w-1:0]; // Upper bits ignored

   always_comb begin
      case (issue.op)
         alu_and: logic_result = issue.operand_1 & issue.operand_2;
         alu_or:  logic_result = issue.operand_1 | issue.operand_2;
         alu_xor: logic_result = issue.operand_1 ^ issue.operand_2;
         alu_sll: logic_result = issue.operand_1 << shamt;
         alu_srl: logic_result = issue.operand_1 >> shamt;
         // Sign bit fills from the left
         alu_sra: logic_result = word_t'($signed(issue.operand_1) >>> shamt);
         default: logic_result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/ieu_branch_check.sv ====
// Speculation check and predictor report
`timescale 1ns/1ps
`default_nettype none

`include "ieu_settings.svh"

module ieu_branch_check (
   input  ieu_isa_pkg::issue_t       issue,
   input  logic                      accept,
   input  logic                      flag_cc,
   output ieu_flow_pkg::redirect_t   raw_redirect,
   output ieu_flow_pkg::bpu_report_t bpu
);

   import ieu_isa_pkg::*;
   import ieu_flow_pkg::*;

   pc_t  jmpfar_tgt;
   logic is_jmprel;
   logic is_jmpfar;
   logic mispredict;

   // Register target, alignment not checked
   assign jmpfar_tgt = issue.operand_1[`IEU_AW-1:2];

   assign is_jmprel = (issue.branch == br_jmprel);
   assign is_jmpfar = (issue.branch == br_jmpfar);

   assign mispredict = accept &
      ((is_jmprel & (issue.specul_bcc != flag_cc)) |
       (is_jmpfar & (issue.specul_tgt != jmpfar_tgt)));

   assign raw_redirect.flush  = mispredict;
   assign raw_redirect.target = is_jmpfar ? jmpfar_tgt :
                                is_jmprel ? issue.specul_tgt : '0;

   assign bpu.valid   = accept & (is_jmprel | is_jmpfar);
   assign bpu.jmprel  = is_jmprel;
   assign bpu.hit     = ~raw_redirect.flush;
   assign bpu.insn_pc = issue.insn_pc;

endmodule

`default_nettype wire

// ==== verilog/ieu_flush_ctrl.sv ====
// Flush hold FSM
`timescale 1ns/1ps
`default_nettype none

module ieu_flush_ctrl (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    in_valid,
   output logic                    in_ready,
   output logic                    accept,
   input  ieu_flow_pkg::redirect_t raw_redirect,
   input  logic                    flush_ack,
   output ieu_flow_pkg::redirect_t redirect
);

   import ieu_flow_pkg::*;

   flush_state_e state_q;
   flush_state_e state_d;
   redirect_t    captured_q;
   logic         busy;

   // Ack is seen in the same cycle, so hold ends without a bubble
   assign busy     = (state_q == fl_hold) & ~flush_ack;
   assign in_ready = ~busy;
   assign accept   = in_valid & in_ready;
   assign redirect = busy ? captured_q : raw_redirect;

   always_comb begin
      state_d = state_q;
      case (state_q)
         fl_idle: begin
            // Flush acked in its first cycle needs no hold
            if (raw_redirect.flush && !flush_ack)
               state_d = fl_hold;
         end
         fl_hold: begin
            // Ack belongs to the held flush, a new one starts over
            if (flush_ack)
               state_d = raw_redirect.flush ? fl_hold : fl_idle;
         end
         default: state_d = fl_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state_q <= fl_idle;
      else
         state_q <= state_d;
   end

   always_ff @(posedge clk) begin
      if (!busy)
         captured_q <= raw_redirect; // Frozen while holding
   end

endmodule

`default_nettype wire

// ==== verilog/ieu_writeback.sv ====
// Regfile write port
`timescale 1ns/1ps
`default_nettype none

module ieu_writeback (
   input  ieu_isa_pkg::issue_t    issue,
   input  logic                   accept,
   input  ieu_isa_pkg::word_t     arith_result,
   input  ieu_isa_pkg::word_t     logic_result,
   output logic                   regf_we,
   output ieu_isa_pkg::reg_addr_t regf_addr,
   output ieu_isa_pkg::word_t     regf_din
);

   import ieu_isa_pkg::*;

   word_t link_addr;

   // Address of the instruction after the jump
   assign link_addr = word_t'({issue.insn_pc + 1'b1, 2'b00});

   always_comb begin
      case (issue.op)
         alu_add,
         alu_sub:  regf_din = arith_result;
         alu_and,
         alu_or,
         alu_xor,
         alu_sll,
         alu_srl,
         alu_sra:  regf_din = logic_result;
         alu_link: regf_din = link_addr;
         default:  regf_din = '0;  // Compares write the flag only
      endcase
   end

   assign regf_addr = issue.wb_addr;
   assign regf_we   = accept & issue.wb_en; // Regfile never stalls

endmodule

`default_nettype wire

// ==== verilog/ieu_top.sv ====
// Integer execute stage
`timescale 1ns/1ps
`default_nettype none

module ieu_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      in_valid,
   input  ieu_isa_pkg::issue_t       issue,
   output logic                      in_ready,
   input  logic                      flag_cc,
   output logic                      cc_we,
   output logic                      cc_nxt,
   output logic                      regf_we,
   output ieu_isa_pkg::reg_addr_t    regf_addr,
   output ieu_isa_pkg::word_t        regf_din,
   output ieu_flow_pkg::redirect_t   redirect,
   input  logic                      flush_ack,
   output ieu_flow_pkg::bpu_report_t bpu
);

   import ieu_isa_pkg::*;
   import ieu_flow_pkg::*;

   logic      accept;
   word_t     arith_result;
   word_t     logic_result;
   redirect_t raw_redirect;  // Before hold

   ieu_arith_unit u_arith (
      .issue        (issue),
      .arith_result (arith_result),
      .accept       (accept),
      .cc_we        (cc_we),
      .cc_nxt       (cc_nxt)
   );

   ieu_logic_unit u_logic (
      .issue        (issue),
      .logic_result (logic_result)
   );

   ieu_branch_check u_branch (
      .issue        (issue),
      .accept       (accept),
      .flag_cc      (flag_cc),
      .raw_redirect (raw_redirect),
      .bpu          (bpu)
   );

   ieu_flush_ctrl u_flush (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .accept       (accept),
      .raw_redirect (raw_redirect),
      .flush_ack    (flush_ack),
      .redirect     (redirect)
   );

   ieu_writeback u_wb (
      .issue        (issue),
      .accept       (accept),
      .arith_result (arith_result),
      .logic_result (logic_result),
      .regf_we      (regf_we),
      .regf_addr    (regf_addr),
      .regf_din     (regf_din)
   );

endmodule

`default_nettype wire

// ==== tb/ieu_props.sv ====
// Execute stage protocol assertions
`timescale 1ns/1ps
`default_nettype none

module ieu_props (
   input logic                    clk,
   input logic                    rst_n,
   input logic                    in_valid,
   input logic                    in_ready,
   input ieu_isa_pkg::issue_t     issue,
   input logic                    regf_we,
   input logic                    cc_we,
   input ieu_flow_pkg::redirect_t redirect,
   input logic                    flush_ack
);

   int fail_count = 0;  // Failed assertions so far

   // Issue held while stalled
   a_issue_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (in_valid && !in_ready) |=> $stable(issue))
      else begin
         $error("issue changed while in_ready was low");
         fail_count++;
      end

   a_regf_we: assert property (@(posedge clk) disable iff (!rst_n)
      regf_we |-> (in_valid && in_ready))
      else begin
         $error("regf_we high outside an accept cycle");
         fail_count++;
      end

   a_cc_we: assert property (@(posedge clk) disable iff (!rst_n)
      cc_we |-> (in_valid && in_ready))
      else begin
         $error("cc_we high outside an accept cycle");
         fail_count++;
      end

   // Flush and target frozen until the ack cycle
   a_redirect_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (redirect.flush && !flush_ack) |=> (flush_ack || $stable(redirect)))
      else begin
         $error("redirect changed before flush_ack");
         fail_count++;
      end

endmodule

bind ieu_top ieu_props u_props (
   .clk       (clk),
   .rst_n     (rst_n),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .issue     (issue),
   .regf_we   (regf_we),
   .cc_we     (cc_we),
   .redirect  (redirect),
   .flush_ack (flush_ack)
);

`default_nettype wire

// ==== tb/ieu_tb.sv ====
// Execute stage testbench
`timescale 1ns/1ps
`default_nettype none

`include "ieu_settings.svh"

module ieu_tb;

   import ieu_isa_pkg::*;
   import ieu_flow_pkg::*;

   localparam int          half_period  = 50;
   localparam int          reset_cycles = 16;
   localparam logic [31:0] seed         = 32'hbb72_6a4a;
   localparam int          n_rand       = 16;  // Loop length of each test
   // Eleven instructions per loop step and up to 8 cycles each with an ack wait
   localparam longint      watchdog_ns  = 2 * 100 * (reset_cycles + 11 * n_rand * 8);

   localparam alu_op_e alu_ops [8] = '{alu_add, alu_sub, alu_and, alu_or,
                                       alu_xor, alu_sll, alu_srl, alu_sra};
   localparam alu_op_e cmp_ops [3] = '{alu_cmp_eq, alu_cmp_lt, alu_cmp_ltu};
   localparam word_t   edge_a [6]  = '{32'h0, 32'h8000_0000, 32'h7fff_ffff,
                                       32'hffff_ffff, 32'h1, 32'h8000_0000};
   localparam word_t   edge_b [6]  = '{32'h0, 32'h7fff_ffff, 32'h8000_0000,
                                       32'h0, 32'hffff_ffff, 32'h8000_0000};

   logic        clk        = 1'b0;
   logic        rst_n      = 1'b0;
   logic        in_valid   = 1'b0;
   issue_t      issue      = '0;
   logic        flag_cc    = 1'b0;  // Condition flag register outside the stage
   logic        flush_ack  = 1'b0;
   logic        in_ready;
   logic        cc_we;
   logic        cc_nxt;
   logic        regf_we;
   reg_addr_t   regf_addr;
   word_t       regf_din;
   redirect_t   redirect;
   bpu_report_t bpu;

   logic        model_flag = 1'b0;
   int          checks     = 0;
   int          errors     = 0;
   int          tests      = 0;
   int          mark_checks = 0;
   int          mark_errors = 0;

   ieu_top u_ieu_top (.*);

   always #half_period clk = ~clk;

   // Flag follows committed compares
   always @(posedge clk) begin
      if (!rst_n)
         flag_cc <= 1'b0;
      else if (cc_we)
         flag_cc <= cc_nxt;
   end

   // Fetch answers each flush after a random wait
   initial begin
      int delay;
      forever begin
         @(negedge clk);
         if (rst_n && redirect.flush) begin
            delay = $urandom_range(4, 1);
            repeat (delay) @(posedge clk);
            flush_ack <= 1'b1;
            @(posedge clk);
            flush_ack <= 1'b0;
         end
      end
   end

   initial begin
      #(watchdog_ns);
      $display("Watchdog expired after %0d ns, the DUT stopped accepting", watchdog_ns);
      $display("Simulation FAILED");
      $finish;
   end

   function automatic word_t model_result(issue_t insn);
      logic [4:0] sh;
      sh = insn.operand_2[4:0];
      case (insn.op)
         alu_add:  return insn.operand_1 + insn.operand_2;
         alu_sub:  return insn.operand_1 + ~insn.operand_2 + 32'd1;
         alu_and:  return insn.operand_1 & insn.operand_2;
         alu_or:   return insn.operand_1 | insn.operand_2;
         alu_xor:  return insn.operand_1 ^ insn.operand_2;
         alu_sll:  return insn.operand_1 << sh;
         alu_srl:  return insn.operand_1 >> sh;
         // Vacated upper bits take the sign
         alu_sra:  return (insn.operand_1 >> sh) |
                          ({32{insn.operand_1[31]}} & ~(32'hffff_ffff >> sh));
         alu_link: return (word_t'(insn.insn_pc) << 2) + 32'd4;  // Next byte address
         default:  return '0;
      endcase
   endfunction

   function automatic logic model_cmp(issue_t insn);
      case (insn.op)
         alu_cmp_eq:  return insn.operand_1 == insn.operand_2;
         alu_cmp_lt:  return (insn.operand_1[31] != insn.operand_2[31]) ?
                             insn.operand_1[31] : (insn.operand_1 < insn.operand_2);
         alu_cmp_ltu: return insn.operand_1 < insn.operand_2;
         default:     return 1'b0;
      endcase
   endfunction

   function automatic issue_t rand_insn(alu_op_e op, logic wb_en);
      issue_t insn;
      insn            = '0;
      insn.operand_1  = $urandom;
      insn.operand_2  = $urandom;
      insn.op         = op;
      insn.wb_en      = wb_en;
      insn.wb_addr    = reg_addr_t'($urandom);
      insn.insn_pc    = pc_t'($urandom);
      insn.specul_tgt = pc_t'($urandom);
      return insn;
   endfunction

   task automatic check_bit(input string test, input string what, input logic exp,
                            input logic act);
      checks++;
      assert (exp === act) else begin
         $display("Fail %s: %s expected %0b actual %0b", test, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_word(input string test, input string what, input word_t exp,
                             input word_t act);
      checks++;
      assert (exp === act) else begin
         $display("Fail %s: %s expected %h actual %h", test, what, exp, act);
         errors++;
      end
   endtask

   // Compare all outputs of an accept cycle against the rules of the stage
   task automatic check_accept(input string test, input issue_t insn);
      logic is_cmp;
      logic mispredict;
      pc_t  far_tgt;
      is_cmp     = insn.op inside {alu_cmp_eq, alu_cmp_lt, alu_cmp_ltu};
      far_tgt    = insn.operand_1[`IEU_AW-1:2];
      mispredict = (insn.branch == br_jmprel && insn.specul_bcc != model_flag) ||
                   (insn.branch == br_jmpfar && insn.specul_tgt != far_tgt);
      check_bit(test, "regf_we", insn.wb_en, regf_we);
      if (insn.wb_en) begin
         check_word(test, "regf_addr", word_t'(insn.wb_addr), word_t'(regf_addr));
         check_word(test, "regf_din", model_result(insn), regf_din);
      end
      check_bit(test, "cc_we", is_cmp, cc_we);
      if (is_cmp) begin
         check_bit(test, "cc_nxt", model_cmp(insn), cc_nxt);
         model_flag = model_cmp(insn);
      end
      check_bit(test, "redirect.flush", mispredict, redirect.flush);
      if (mispredict)
         check_word(test, "redirect.target",
                    word_t'(insn.branch == br_jmpfar ? far_tgt : insn.specul_tgt),
                    word_t'(redirect.target));
      check_bit(test, "bpu.valid", insn.branch != br_none, bpu.valid);
      if (insn.branch != br_none) begin
         check_bit(test, "bpu.hit", !mispredict, bpu.hit);
         check_bit(test, "bpu.jmprel", insn.branch == br_jmprel, bpu.jmprel);
         check_word(test, "bpu.insn_pc", word_t'(insn.insn_pc), word_t'(bpu.insn_pc));
      end
   endtask

   // Offer one instruction and wait for its accept cycle
   task automatic run_insn(input string test, input issue_t insn, input logic held,
                           input pc_t held_tgt);
      @(posedge clk);
      in_valid <= 1'b1;
      issue    <= insn;
      @(negedge clk);
      while (!in_ready) begin
         assert (held) else begin
            $display("Fail %s: in_ready low with no flush pending", test);
            errors++;
         end
         check_bit(test, "held redirect.flush", 1'b1, redirect.flush);
         if (held)
            check_word(test, "held redirect.target", word_t'(held_tgt),
                       word_t'(redirect.target));
         @(negedge clk);
      end
      if (held)
         check_bit(test, "flush_ack at release", 1'b1, flush_ack);
      check_accept(test, insn);
   endtask

   task automatic end_test(input string test);
      @(posedge clk);
      in_valid <= 1'b0;
      tests++;
      $display("Test %s done, %0d checks, %0d errors", test, checks - mark_checks,
               errors - mark_errors);
      mark_checks = checks;
      mark_errors = errors;
   endtask

   initial begin
      issue_t insn;
      pc_t    held_tgt;
      void'($urandom(seed));

      for (int i = 0; i <= reset_cycles; i++) begin
         @(negedge clk);
         check_bit("reset", "in_ready", 1'b1, in_ready);
         check_bit("reset", "regf_we", 1'b0, regf_we);
         check_bit("reset", "cc_we", 1'b0, cc_we);
         check_bit("reset", "redirect.flush", 1'b0, redirect.flush);
         check_bit("reset", "bpu.valid", 1'b0, bpu.valid);
         if (i == reset_cycles - 1) begin
            @(posedge clk);
            rst_n <= 1'b1;
         end
      end
      end_test("reset");

      for (int i = 0; i < n_rand; i++)
         run_insn("alu", rand_insn(alu_ops[i % 8], i % 5 != 4), 1'b0, '0);
      end_test("alu");

      for (int i = 0; i < 3 * n_rand; i++) begin
         insn = rand_insn(cmp_ops[i % 3], 1'b0);
         if (i < 18) begin
            insn.operand_1 = edge_a[i / 3];
            insn.operand_2 = edge_b[i / 3];
         end else if (i % 4 == 0)
            insn.operand_2 = insn.operand_1;
         run_insn("compare", insn, 1'b0, '0);
      end
      end_test("compare");

      for (int i = 0; i < n_rand; i++) begin
         insn = rand_insn(alu_link, 1'b1);
         if (i == 0)
            insn.insn_pc = '1;  // Wraps to zero
         run_insn("link", insn, 1'b0, '0);
      end
      end_test("link");

      for (int i = 0; i < n_rand; i++) begin
         insn = rand_insn(alu_cmp_eq, 1'b0);
         if (i % 2 == 1)
            insn.operand_2 = insn.operand_1;  // Sets the flag
         run_insn("spec_hit", insn, 1'b0, '0);
         insn            = rand_insn(alu_none, 1'b0);
         insn.branch     = br_jmprel;
         insn.specul_bcc = model_flag;
         run_insn("spec_hit", insn, 1'b0, '0);
         insn            = rand_insn(alu_link, 1'b1);
         insn.branch     = br_jmpfar;
         insn.specul_tgt = insn.operand_1[`IEU_AW-1:2];
         run_insn("spec_hit", insn, 1'b0, '0);
      end
      end_test("spec_hit");

      for (int i = 0; i < n_rand; i++) begin
         insn            = rand_insn(i % 2 ? alu_link : alu_none, i % 2 == 1);
         insn.branch     = (i % 2) ? br_jmpfar : br_jmprel;
         insn.specul_bcc = ~model_flag;
         if (i % 2 == 1) begin
            insn.specul_tgt = ~insn.operand_1[`IEU_AW-1:2];
            held_tgt        = insn.operand_1[`IEU_AW-1:2];
         end else
            held_tgt = insn.specul_tgt;
         run_insn("mispredict", insn, 1'b0, '0);
         // First follower waits out the hold as a write or a compare
         run_insn("mispredict", rand_insn(i % 4 < 2 ? alu_add : alu_cmp_eq, i % 4 < 2),
                  1'b1, held_tgt);
         run_insn("mispredict", rand_insn(alu_cmp_ltu, 1'b0), 1'b0, '0);
      end
      end_test("mispredict");

      $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d", tests, checks,
               errors, u_ieu_top.u_props.fail_count);
      if (errors == 0 && u_ieu_top.u_props.fail_count == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
verilog/ieu_flow_pkg.sv
verilog/ieu_isa_pkg.sv
verilog/ieu_arith_unit.sv
verilog/ieu_logic_unit.sv
verilog/ieu_branch_check.sv
verilog/ieu_flush_ctrl.sv
verilog/ieu_writeback.sv
verilog/ieu_top.sv
tb/ieu_props.sv
tb/ieu_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the execute stage

VERILATOR ?= verilator
TOP       ?= ieu_tb
LINT_TOP  ?= ieu_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
